/* logic/pad_pkg.sv */
////////////////////
// Gamepad package
// Serial controller timing constants and the
// button report layout shared by the input path
////////////////////

package pad_pkg;

    // Two SNES-style controller ports
    localparam int NUM_PADS = 2;
    localparam int PAD_BITS = 12;

    // pad_clk half period and poll period, in clk_2x cycles
    localparam int PAD_CLK_HALF = 4;
    localparam int BIT_PERIOD = 2 * PAD_CLK_HALF;
    localparam int POLL_INTERVAL = 512;

    // Counter widths
    localparam int INTERVAL_W = $clog2(POLL_INTERVAL);
    localparam int PHASE_W = $clog2(BIT_PERIOD);
    localparam int BIT_IDX_W = $clog2(PAD_BITS + 1);

    // Sized compare values for the counters
    localparam logic [INTERVAL_W-1:0] INTERVAL_LAST = INTERVAL_W'(POLL_INTERVAL - 1);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(BIT_PERIOD - 1);
    localparam logic [PHASE_W-1:0] PHASE_HIGH = PHASE_W'(PAD_CLK_HALF);
    localparam logic [BIT_IDX_W-1:0] BIT_LAST = BIT_IDX_W'(PAD_BITS - 1);
    localparam logic [BIT_IDX_W-1:0] BIT_END = BIT_IDX_W'(PAD_BITS);

    // Button order as shifted out by the controller, b first
    typedef struct packed {
        logic r;
        logic l;
        logic x;
        logic a;
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic y;
        logic b;
    } pad_buttons_t;

    // Same word seen raw or by button name
    typedef union packed {
        logic [PAD_BITS-1:0] raw;
        pad_buttons_t buttons;
    } pad_report_u;

endpackage

/* logic/pad_scan_if.sv */
////////////////////
// Gamepad scan interface
// Latch, controller clock and sampling strobes
// from the poll timer
////////////////////

interface pad_scan_if;

    // Pin-level timing
    logic latch;
    logic pad_clk;

    // One-cycle strobes
    logic sample;
    logic frame_done;

    modport timer (
        output latch,
        output pad_clk,
        output sample,
        output frame_done
    );

    // Shift ports only need the strobes
    modport port (
        input sample,
        input frame_done
    );

    modport hold (
        input frame_done
    );

endinterface

/* logic/pad_poll_timer.sv */
////////////////////
// Gamepad poll timer
// Counts out the poll interval and produces latch,
// pad_clk and the sample and frame end strobes
////////////////////

module pad_poll_timer (
    input  logic      clk_2x,
    input  logic      reset,
    pad_scan_if.timer scan
);

    logic [pad_pkg::INTERVAL_W-1:0] interval_cnt;
    logic [pad_pkg::PHASE_W-1:0]    phase;
    logic [pad_pkg::BIT_IDX_W-1:0]  bit_cnt;

    logic scanning;
    logic latch_next;
    logic clk_low_next;
    logic sample_next;
    logic done_next;

    // Bit 0 is the latch window, bits 1 to 11 each get one pad_clk pulse
    always_comb begin
        scanning = bit_cnt < pad_pkg::BIT_END;
        latch_next = scanning && (bit_cnt == '0);
        clk_low_next = scanning && (bit_cnt != '0) && (phase < pad_pkg::PHASE_HIGH);

        // Sample at the end of each bit period, just before the next shift
        sample_next = scanning && (phase == pad_pkg::PHASE_LAST);
        done_next = sample_next && (bit_cnt == pad_pkg::BIT_LAST);
    end

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            interval_cnt <= '0;
            phase <= '0;
            bit_cnt <= '0;
        end else if (interval_cnt == pad_pkg::INTERVAL_LAST) begin
            // Start of next poll
            interval_cnt <= '0;
            phase <= '0;
            bit_cnt <= '0;
        end else begin
            interval_cnt <= interval_cnt + 1'b1;

            if (scanning) begin
                if (phase == pad_pkg::PHASE_LAST) begin
                    phase <= '0;
                    bit_cnt <= bit_cnt + 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    // Registered so the pins come straight from flops
    always_ff @(posedge clk_2x) begin
        if (reset) begin
            scan.latch <= 1'b0;
            scan.pad_clk <= 1'b1;
            scan.sample <= 1'b0;
            scan.frame_done <= 1'b0;
        end else begin
            scan.latch <= latch_next;
            scan.pad_clk <= !clk_low_next;
            scan.sample <= sample_next;
            scan.frame_done <= done_next;
        end
    end

endmodule

/* logic/pad_port.sv */
////////////////////
// Gamepad shift port
// Collects one controller's serial bits into a report
////////////////////

module pad_port (
    input  logic                clk_2x,
    input  logic                reset,
    pad_scan_if.port            scan,
    input  logic                pad_data,
    output pad_pkg::pad_report_u report
);

    logic [pad_pkg::PAD_BITS-1:0]  shift_reg;
    logic [pad_pkg::PAD_BITS-1:0]  shift_next;
    logic [pad_pkg::BIT_IDX_W-1:0] bit_idx;

    // Data line is active low, a pressed button reads as 0
    always_comb begin
        shift_next = shift_reg;
        shift_next[bit_idx] = ~pad_data;
    end

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            bit_idx <= '0;
        end else if (scan.frame_done) begin
            // Next frame starts at bit 0 again
            bit_idx <= '0;
        end else if (scan.sample) begin
            bit_idx <= bit_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_2x) begin
        if (scan.sample) begin
            shift_reg <= shift_next;
        end

        // Last bit arrives with frame_done, so commit shift_next
        if (scan.frame_done) begin
            report.raw <= shift_next;
        end
    end

endmodule

/* logic/pad_report_hold.sv */
////////////////////
// Gamepad report holder
// Keeps the latest button words, flags new presses
// and raises the soft reset combo
////////////////////

module pad_report_hold (
    input  logic                                        clk_2x,
    input  logic                                        reset,
    pad_scan_if.hold                                    scan,
    input  pad_pkg::pad_report_u                        reports [pad_pkg::NUM_PADS],
    output logic [pad_pkg::PAD_BITS-1:0]                p1_buttons,
    output logic [pad_pkg::PAD_BITS-1:0]                p2_buttons,
    output logic                                        report_valid,
    output logic [pad_pkg::NUM_PADS*pad_pkg::PAD_BITS-1:0] press_events,
    output logic                                        reset_request
);

    logic frame_seen;
    pad_pkg::pad_report_u held [pad_pkg::NUM_PADS];

    logic [pad_pkg::NUM_PADS*pad_pkg::PAD_BITS-1:0] new_events;
    logic combo_now;
    logic combo_prev;

    // held still has last frame's words when the new ones arrive
    always_comb begin
        for (int i = 0; i < pad_pkg::NUM_PADS; i++) begin
            new_events[i*pad_pkg::PAD_BITS +: pad_pkg::PAD_BITS] =
                reports[i].raw & ~held[i].raw;
        end

        // Start + select + L + R on P1
        combo_now = reports[0].buttons.start & reports[0].buttons.select &
                    reports[0].buttons.l & reports[0].buttons.r;
        combo_prev = held[0].buttons.start & held[0].buttons.select &
                     held[0].buttons.l & held[0].buttons.r;
    end

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            frame_seen <= 1'b0;
            report_valid <= 1'b0;
            press_events <= '0;
            reset_request <= 1'b0;

            for (int i = 0; i < pad_pkg::NUM_PADS; i++) begin
                held[i] <= '0;
            end
        end else begin
            // Port reports settle one cycle after frame_done
            frame_seen <= scan.frame_done;
            report_valid <= frame_seen;

            if (frame_seen) begin
                for (int i = 0; i < pad_pkg::NUM_PADS; i++) begin
                    held[i] <= reports[i];
                end

                press_events <= new_events;
                reset_request <= combo_now & ~combo_prev;
            end else begin
                // Events are only meaningful alongside report_valid
                press_events <= '0;
                reset_request <= 1'b0;
            end
        end
    end

    assign p1_buttons = held[0].raw;
    assign p2_buttons = held[1].raw;

endmodule

/* logic/gamepad_top.sv */
////////////////////
// Gamepad input path
// Polls two serial controllers and reports buttons,
// press events and the soft reset request
////////////////////

module gamepad_top (
    input  logic                                           clk_2x,
    input  logic                                           reset,

    // Controller pins
    output logic                                           pad_latch,
    output logic                                           pad_clk,
    input  logic [pad_pkg::NUM_PADS-1:0]                   pad_data,

    // Button state
    output logic [pad_pkg::PAD_BITS-1:0]                   p1_buttons,
    output logic [pad_pkg::PAD_BITS-1:0]                   p2_buttons,
    output logic                                           report_valid,
    output logic [pad_pkg::NUM_PADS*pad_pkg::PAD_BITS-1:0] press_events,
    output logic                                           reset_request
);

    pad_scan_if scan ();

    pad_pkg::pad_report_u reports [pad_pkg::NUM_PADS];

    pad_poll_timer pad_poll_timer_inst (
        .clk_2x(clk_2x),
        .reset(reset),
        .scan(scan)
    );

    // One shift port per controller, all sharing latch and pad_clk
    for (genvar i = 0; i < pad_pkg::NUM_PADS; i++) begin : g_port
        pad_port pad_port_inst (
            .clk_2x(clk_2x),
            .reset(reset),
            .scan(scan),
            .pad_data(pad_data[i]),
            .report(reports[i])
        );
    end

    pad_report_hold pad_report_hold_inst (
        .clk_2x(clk_2x),
        .reset(reset),
        .scan(scan),
        .reports(reports),
        .p1_buttons(p1_buttons),
        .p2_buttons(p2_buttons),
        .report_valid(report_valid),
        .press_events(press_events),
        .reset_request(reset_request)
    );

    assign pad_latch = scan.latch;
    assign pad_clk = scan.pad_clk;

endmodule

/* bench/pad_clock_gen.sv */
////////////////////
// Testbench clock and reset
////////////////////

module pad_clock_gen (
    output logic clk_2x,
    output logic reset
);

    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_2x = 1'b0;
        forever #(HALF_PERIOD) clk_2x = ~clk_2x;
    end

    // Released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_2x);
        reset <= 1'b0;
    end

endmodule

/* bench/gamepad_assert.sv */
////////////////////
// Poll timer assertions
// Latch width, pad_clk idle during latch
// and frame_done alignment
////////////////////

module gamepad_assert (
    input logic clk_2x,
    input logic reset,
    input logic latch,
    input logic pad_clk,
    input logic sample,
    input logic frame_done
);

    localparam int LATCH_CYCLES = 8;

    // Samples before the last one of a frame
    localparam int DONE_SAMPLE = 11;

    logic [3:0] latch_len;
    logic [3:0] sample_cnt;

    // Length of the current latch pulse so far
    always_ff @(posedge clk_2x) begin
        if (reset) begin
            latch_len <= '0;
        end else if (latch) begin
            latch_len <= latch_len + 1'b1;
        end else begin
            latch_len <= '0;
        end
    end

    // Samples seen since the latch rose
    always_ff @(posedge clk_2x) begin
        if (reset) begin
            sample_cnt <= '0;
        end else if (latch && latch_len == '0) begin
            sample_cnt <= '0;
        end else if (sample) begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    latch_width: assert property (@(posedge clk_2x) disable iff (reset)
        $fell(latch) |-> (latch_len == LATCH_CYCLES))
        else $error("latch pulse width is not %0d cycles", LATCH_CYCLES);

    latch_ends: assert property (@(posedge clk_2x) disable iff (reset)
        $rose(latch) |-> ##(LATCH_CYCLES) !latch)
        else $error("latch still high %0d cycles after it rose", LATCH_CYCLES);

    // No pad_clk rise may fall inside the latch window
    clk_idle_in_latch: assert property (@(posedge clk_2x) disable iff (reset)
        latch |-> (pad_clk && $past(pad_clk)))
        else $error("pad_clk low while latch is high or just before it");

    done_with_sample: assert property (@(posedge clk_2x) disable iff (reset)
        (sample || frame_done) |->
            (sample && (frame_done == (sample_cnt == DONE_SAMPLE))))
        else $error("frame_done does not coincide with the twelfth sample");

endmodule

bind pad_poll_timer gamepad_assert gamepad_assert_inst (
    .clk_2x(clk_2x),
    .reset(reset),
    .latch(scan.latch),
    .pad_clk(scan.pad_clk),
    .sample(scan.sample),
    .frame_done(scan.frame_done)
);

/* bench/gamepad_tb.sv */
////////////////////
// Gamepad testbench
// Random serial controller models, a reference
// model of the reports and protocol timing checks
////////////////////

module gamepad_tb;

    localparam int NUM_FRAMES = 40;
    localparam int NUM_TESTS = 6;
    localparam int CLK_PERIOD = 10;
    localparam int PAD_CLK_RISES = pad_pkg::PAD_BITS - 1;
    localparam int WATCHDOG_TIME = (NUM_FRAMES + 2) * pad_pkg::POLL_INTERVAL * CLK_PERIOD + 5000;

    // Start, select, L and R in controller bit order
    localparam logic [11:0] COMBO_MASK = 12'hc0c;

    logic        clk_2x;
    logic        reset;
    logic [1:0]  pad_data = 2'b11;
    logic        pad_latch;
    logic        pad_clk;
    logic [11:0] p1_buttons;
    logic [11:0] p2_buttons;
    logic        report_valid;
    logic [23:0] press_events;
    logic        reset_request;

    integer seed = 32'h940f2cf8;

    // Controller model state
    logic [11:0] p1_word = '0;
    logic [11:0] p2_word = '0;
    logic [11:0] shift_word [2] = '{default: '0};
    logic        model_latch = 1'b0;
    logic        model_pclk = 1'b1;
    int          clk_edges = 0;

    // Reference model, {p2, p1} per frame
    logic [23:0] sent_words [$];
    logic [11:0] prev_p1 = '0;
    logic [11:0] prev_p2 = '0;
    int          reports_seen = 0;
    int          errors [1:NUM_TESTS] = '{default: 0};

    // Timing monitor state
    int   cycle = 0;
    int   last_rise = 0;
    int   latch_rises = 0;
    int   pclk_rises = 0;
    int   valid_pulses = 0;
    logic mon_latch = 1'b0;
    logic mon_pclk = 1'b1;
    logic mon_valid = 1'b0;

    pad_clock_gen pad_clock_gen_inst (
        .clk_2x(clk_2x),
        .reset(reset)
    );

    gamepad_top gamepad_top_inst (
        .clk_2x(clk_2x),
        .reset(reset),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .pad_data(pad_data),
        .p1_buttons(p1_buttons),
        .p2_buttons(p2_buttons),
        .report_valid(report_valid),
        .press_events(press_events),
        .reset_request(reset_request)
    );

    function automatic logic holds_combo(input logic [11:0] word);
        return (word & COMBO_MASK) == COMBO_MASK;
    endfunction

    task automatic report_test(input int num, input string name);
        if (errors[num] == 0) begin
            $display("test %0d (%s): PASS", num, name);
        end else begin
            $display("test %0d (%s): FAIL with %0d errors", num, name, errors[num]);
        end
    endtask

    // Controllers load on latch and shift on each pad_clk rise
    always @(posedge clk_2x) begin
        clk_edges++;
        if (!reset) begin
            if (pad_latch && !model_latch) begin
                p1_word = 12'($random(seed));
                p2_word = 12'($random(seed));
                if (($random(seed) & 3) == 0) begin
                    p1_word = p1_word | COMBO_MASK;
                end
                sent_words.push_back({p2_word, p1_word});
            end
            if (pad_latch) begin
                shift_word[0] = p1_word;
                shift_word[1] = p2_word;
            end else if (pad_clk && !model_pclk) begin
                shift_word[0] = shift_word[0] >> 1;
                shift_word[1] = shift_word[1] >> 1;
            end
            // Pressed buttons pull the line low
            pad_data <= ~{shift_word[1][0], shift_word[0][0]};
        end
        model_latch = pad_latch;
        model_pclk = pad_clk;
    end

    // Output checks, sampled mid-cycle
    always @(negedge clk_2x) begin
        logic [23:0] sent;
        logic [23:0] exp_events;
        logic        exp_reset;

        if (clk_edges == 0) begin
            // Nothing clocked into the DUT yet
        end else if (reset) begin
            assert (pad_latch == 1'b0 && pad_clk == 1'b1 && report_valid == 1'b0 &&
                    p1_buttons == '0 && p2_buttons == '0 && press_events == '0 &&
                    reset_request == 1'b0)
            else begin
                $display("MISMATCH at %0t: outputs not at reset values during reset", $time);
                errors[1]++;
            end
        end else if (report_valid) begin
            if (sent_words.size() == 0) begin
                $display("ERROR at %0t: report_valid with no frame sent by the controllers",
                         $time);
                errors[2]++;
            end else begin
                sent = sent_words.pop_front();
                exp_events = {sent[23:12] & ~prev_p2, sent[11:0] & ~prev_p1};
                exp_reset = holds_combo(sent[11:0]) && !holds_combo(prev_p1);

                assert (p1_buttons == sent[11:0] && p2_buttons == sent[23:12])
                else begin
                    $display("MISMATCH at %0t: buttons p1 %h p2 %h, expected p1 %h p2 %h",
                             $time, p1_buttons, p2_buttons, sent[11:0], sent[23:12]);
                    errors[2]++;
                end
                assert (press_events == exp_events)
                else begin
                    $display("MISMATCH at %0t: press_events %h, expected %h",
                             $time, press_events, exp_events);
                    errors[3]++;
                end
                assert (reset_request == exp_reset)
                else begin
                    $display("MISMATCH at %0t: reset_request %b, expected %b",
                             $time, reset_request, exp_reset);
                    errors[4]++;
                end
                prev_p1 = sent[11:0];
                prev_p2 = sent[23:12];
            end
            reports_seen++;
        end else begin
            assert (press_events == '0)
            else begin
                $display("MISMATCH at %0t: press_events %h outside report_valid",
                         $time, press_events);
                errors[3]++;
            end
            assert (reset_request == 1'b0)
            else begin
                $display("MISMATCH at %0t: reset_request high outside report_valid", $time);
                errors[4]++;
            end
            if (reports_seen == 0) begin
                assert (p1_buttons == '0 && p2_buttons == '0)
                else begin
                    $display("MISMATCH at %0t: buttons %h %h before the first report",
                             $time, p1_buttons, p2_buttons);
                    errors[1]++;
                end
            end
        end
    end

    // Frame timing, checked for the previous frame at each latch rise
    always @(negedge clk_2x) begin
        if (!reset && clk_edges > 0) begin
            cycle++;
            if (pad_clk && !mon_pclk) begin
                pclk_rises++;
            end
            if (report_valid) begin
                valid_pulses++;
                assert (!mon_valid)
                else begin
                    $display("ERROR at %0t: report_valid high for more than one cycle", $time);
                    errors[6]++;
                end
            end
            if (pad_latch && !mon_latch) begin
                if (latch_rises > 0) begin
                    assert (cycle - last_rise == pad_pkg::POLL_INTERVAL)
                    else begin
                        $display("MISMATCH at %0t: latch rises %0d cycles apart, expected %0d",
                                 $time, cycle - last_rise, pad_pkg::POLL_INTERVAL);
                        errors[5]++;
                    end
                    assert (pclk_rises == PAD_CLK_RISES)
                    else begin
                        $display("MISMATCH at %0t: %0d pad_clk rises in a frame, expected %0d",
                                 $time, pclk_rises, PAD_CLK_RISES);
                        errors[5]++;
                    end
                    assert (valid_pulses == 1)
                    else begin
                        $display("MISMATCH at %0t: %0d report_valid pulses in a frame",
                                 $time, valid_pulses);
                        errors[6]++;
                    end
                end
                latch_rises++;
                last_rise = cycle;
                pclk_rises = 0;
                valid_pulses = 0;
            end
        end
        mon_latch = pad_latch;
        mon_pclk = pad_clk;
        mon_valid = report_valid;
    end

    initial begin
        int passed;
        int failed;
        int total_errors;

        passed = 0;
        failed = 0;
        total_errors = 0;

        wait (reports_seen >= 1);
        report_test(1, "reset state");

        wait (reports_seen >= NUM_FRAMES);
        @(posedge clk_2x);
        report_test(2, "button words");
        report_test(3, "press events");
        report_test(4, "reset combo");

        // One more latch rise closes the timing checks of the last frame
        wait (latch_rises >= NUM_FRAMES + 1);
        @(posedge clk_2x);
        report_test(5, "scan timing");
        report_test(6, "report pulse");

        for (int i = 1; i <= NUM_TESTS; i++) begin
            if (errors[i] == 0) begin
                passed++;
            end else begin
                failed++;
            end
            total_errors += errors[i];
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d frames, %0d errors",
                 NUM_TESTS, passed, failed, reports_seen, total_errors);
        if (failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* flist.f */
logic/pad_pkg.sv
logic/pad_scan_if.sv
logic/pad_poll_timer.sv
logic/pad_port.sv
logic/pad_report_hold.sv
logic/gamepad_top.sv
bench/pad_clock_gen.sv
bench/gamepad_assert.sv
bench/gamepad_tb.sv

/* run_sim.sh */
#!/bin/bash
# Builds the gamepad testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module gamepad_tb \
    -f flist.f -o gamepad_sim \
    && ./obj_dir/gamepad_sim > sim.log 2>&1 \
    || { echo "Build or simulation run did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "Simulation failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "Result: FAIL, no pass line in sim.log"; exit 1; }
echo "Result: PASS"
